//--- flist.f
isb_pkg.sv
isb_training_unit.sv
isb_ps_amc.sv
isb_sp_amc.sv
isb_trainer.sv
isb_apb_regs.sv
isb_top.sv
isb_assertions.sv
tb_isb_checker.sv
tb_isb.sv

//--- isb_apb_regs.sv
`default_nettype none

module isb_apb_regs (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         psel_i,
    input  logic                         penable_i,
    input  logic                         pwrite_i,
    input  logic [7:0]                   paddr_i,
    input  logic [31:0]                  pwdata_i,
    output logic [isb_pkg::PS_IDX_W-1:0] ps_rd_idx_o,
    input  isb_pkg::ps_entry_t           ps_rd_i,
    output logic [isb_pkg::SP_SA_W-1:0]  sp_rd_sa_o,
    input  logic                         sp_valid_i,
    input  logic [isb_pkg::ADDR_W-1:0]   sp_pa_i,
    input  logic [isb_pkg::SA_W-1:0]     next_sa_i,
    output logic [31:0]                  prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o
);
    import isb_pkg::*;

    apb_region_e region;
    logic        setup;
    logic        pready_q;
    logic        pslverr_q;
    logic [31:0] rd_word;

    // word index map
    always_comb begin
        if (paddr_i < 8'h20) begin
            region = REG_PS;
        end else if (paddr_i < 8'h40) begin
            region = REG_SP;
        end else if (paddr_i == 8'h40) begin
            region = REG_STATUS;
        end else begin
            region = REG_NONE;
        end
    end

    assign ps_rd_idx_o = paddr_i[PS_IDX_W-1:0];
    assign sp_rd_sa_o = paddr_i[SP_SA_W-1:0];

    always_comb begin
        rd_word = '0;
        unique case (region)
            REG_PS: begin
                rd_word[31] = ps_rd_i.valid;
                rd_word[28 +: CTR_W] = ps_rd_i.ctr;
                rd_word[16 +: SA_W] = ps_rd_i.sa;
                rd_word[0 +: ADDR_W] = ps_rd_i.tag;
            end
            REG_SP: begin
                rd_word[31] = sp_valid_i;
                rd_word[0 +: ADDR_W] = sp_pa_i;
            end
            REG_STATUS: rd_word[0 +: SA_W] = next_sa_i;
            REG_NONE: rd_word = '0;
        endcase
    end

    // zero wait states, pready rises for the access phase only
    assign setup = psel_i && !penable_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pready_q <= 1'b0;
            pslverr_q <= 1'b0;
        end else begin
            pready_q <= setup;
            // read-only map, any write is an error
            pslverr_q <= setup && (pwrite_i || region == REG_NONE);
        end
    end

    assign pready_o = pready_q;
    assign pslverr_o = pslverr_q;
    assign prdata_o = (pready_q && !pslverr_q) ? rd_word : '0;

endmodule

`default_nettype wire

//--- isb_assertions.sv
`default_nettype none

module isb_assertions (
    input logic                     clk,
    input logic                     arst_n_i,
    input logic                     psel_i,
    input logic                     penable_i,
    input logic                     pready_i,
    input logic                     pslverr_i,
    input logic [isb_pkg::SA_W-1:0] next_sa_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import isb_pkg::*;

    int fail_count = 0;

    a_err_needs_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
        pslverr_i |-> pready_i)
        else begin
            fail_count++;
            $error("pslverr high without pready");
        end

    // zero wait states, so pready only shows in the access phase
    a_ready_in_access: assert property (@(posedge clk) disable iff (!arst_n_i)
        pready_i |-> (psel_i && penable_i))
        else begin
            fail_count++;
            $error("pready high outside an APB access phase");
        end

    a_next_sa_bound: assert property (@(posedge clk) disable iff (!arst_n_i)
        next_sa_i <= SA_W'(SA_SPACE))
        else begin
            fail_count++;
            $error("allocator moved past the structural address space");
        end

endmodule

bind isb_top isb_assertions u_isb_assertions (
    .clk(clk), .arst_n_i(arst_n_i), .psel_i(psel_i), .penable_i(penable_i),
    .pready_i(pready_o), .pslverr_i(pslverr_o), .next_sa_i(next_sa)
);

`default_nettype wire

//--- isb_pkg.sv
`default_nettype none

package isb_pkg;

    // physical address and pc width
    localparam int ADDR_W = 16;

    // ps-amc is direct mapped on the low address bits
    localparam int PS_ENTRIES = 32;
    localparam int PS_IDX_W = $clog2(PS_ENTRIES);

    // one extra bit on sa so that an exhausted allocator reads as SA_SPACE
    localparam int SA_SPACE = 32;
    localparam int SA_W = 6;

    // sp-amc shape, block is sa[4:2] and slot is sa[1:0]
    localparam int SP_BLOCKS = 8;
    localparam int SP_SLOTS = 4;
    localparam int SP_SLOT_W = $clog2(SP_SLOTS);
    localparam int SP_SA_W = $clog2(SA_SPACE);

    localparam int CTR_W = 2;
    // a fresh mapping starts at full confidence
    localparam logic [CTR_W-1:0] CTR_INIT = CTR_W'(3);

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] addr;
    } access_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] pc;
        logic [ADDR_W-1:0] last;
    } tu_entry_t;

    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] tag;
        logic [SA_W-1:0]   sa;
        logic [CTR_W-1:0]  ctr;
    } ps_entry_t;

    typedef struct packed {
        logic                en;
        logic [PS_IDX_W-1:0] idx;
        ps_entry_t           ent;
    } ps_wr_t;

    typedef struct packed {
        logic               en;
        logic [SP_SA_W-1:0] sa;
        logic [ADDR_W-1:0]  pa;
    } sp_wr_t;

    // encoding is {hit_a, hit_b}
    typedef enum logic [1:0] {
        CASE_NEW_PAIR = 2'b00,
        CASE_B_ONLY   = 2'b01,
        CASE_A_ONLY   = 2'b10,
        CASE_BOTH     = 2'b11
    } train_case_e;

    typedef enum logic [1:0] {
        REG_PS,
        REG_SP,
        REG_STATUS,
        REG_NONE
    } apb_region_e;

endpackage

`default_nettype wire

//--- isb_ps_amc.sv
`default_nettype none

module isb_ps_amc (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic [isb_pkg::ADDR_W-1:0]   addr_a_i,
    input  logic [isb_pkg::ADDR_W-1:0]   addr_b_i,
    output logic                         hit_a_o,
    output logic                         hit_b_o,
    output isb_pkg::ps_entry_t           ent_a_o,
    output isb_pkg::ps_entry_t           ent_b_o,
    input  isb_pkg::ps_wr_t              wr_a_i,
    input  isb_pkg::ps_wr_t              wr_b_i,
    input  logic [isb_pkg::PS_IDX_W-1:0] rd_idx_i,
    output isb_pkg::ps_entry_t           rd_ent_o
);
    import isb_pkg::*;

    ps_entry_t mem [PS_ENTRIES];

    // tag is the full address
    assign ent_a_o = mem[addr_a_i[PS_IDX_W-1:0]];
    assign ent_b_o = mem[addr_b_i[PS_IDX_W-1:0]];
    assign hit_a_o = ent_a_o.valid && (ent_a_o.tag == addr_a_i);
    assign hit_b_o = ent_b_o.valid && (ent_b_o.tag == addr_b_i);

    assign rd_ent_o = mem[rd_idx_i];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PS_ENTRIES; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (wr_a_i.en) begin
                mem[wr_a_i.idx] <= wr_a_i.ent;
            end
            // port b last so it wins on a shared index
            if (wr_b_i.en) begin
                mem[wr_b_i.idx] <= wr_b_i.ent;
            end
        end
    end

endmodule

`default_nettype wire

//--- isb_sp_amc.sv
`default_nettype none

module isb_sp_amc (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  isb_pkg::sp_wr_t             wr0_i,
    input  isb_pkg::sp_wr_t             wr1_i,
    input  logic [isb_pkg::SP_SA_W-1:0] rd_sa_i,
    output logic                        rd_valid_o,
    output logic [isb_pkg::ADDR_W-1:0]  rd_pa_o
);
    import isb_pkg::*;

    logic [SP_SLOTS-1:0] valid_q [SP_BLOCKS];
    logic [ADDR_W-1:0]   pa_q    [SP_BLOCKS][SP_SLOTS];

    // block from the upper sa bits, slot from the lower
    assign rd_valid_o = valid_q[rd_sa_i[SP_SA_W-1:SP_SLOT_W]][rd_sa_i[SP_SLOT_W-1:0]];
    assign rd_pa_o = pa_q[rd_sa_i[SP_SA_W-1:SP_SLOT_W]][rd_sa_i[SP_SLOT_W-1:0]];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int b = 0; b < SP_BLOCKS; b++) begin
                valid_q[b] <= '0;
            end
        end else begin
            if (wr0_i.en) begin
                valid_q[wr0_i.sa[SP_SA_W-1:SP_SLOT_W]][wr0_i.sa[SP_SLOT_W-1:0]] <= 1'b1;
            end
            if (wr1_i.en) begin
                valid_q[wr1_i.sa[SP_SA_W-1:SP_SLOT_W]][wr1_i.sa[SP_SLOT_W-1:0]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr0_i.en) begin
            pa_q[wr0_i.sa[SP_SA_W-1:SP_SLOT_W]][wr0_i.sa[SP_SLOT_W-1:0]] <= wr0_i.pa;
        end
        if (wr1_i.en) begin
            pa_q[wr1_i.sa[SP_SA_W-1:SP_SLOT_W]][wr1_i.sa[SP_SLOT_W-1:0]] <= wr1_i.pa;
        end
    end

endmodule

`default_nettype wire

//--- isb_top.sv
`default_nettype none

module isb_top #(
    parameter int TU_ENTRIES = 4,
    parameter int SA_CHUNK = 16
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  isb_pkg::access_t acc_i,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  logic [7:0]       paddr_i,
    input  logic [31:0]      pwdata_i,
    output logic [31:0]      prdata_o,
    output logic             pready_o,
    output logic             pslverr_o
);
    import isb_pkg::*;

    logic                tu_hit;
    logic [ADDR_W-1:0]   tu_last;
    logic                hit_a;
    logic                hit_b;
    ps_entry_t           ent_a;
    ps_entry_t           ent_b;
    ps_wr_t              ps_wr_a;
    ps_wr_t              ps_wr_b;
    sp_wr_t              sp_wr0;
    sp_wr_t              sp_wr1;
    logic [SA_W-1:0]     next_sa;
    logic [PS_IDX_W-1:0] ps_rd_idx;
    ps_entry_t           ps_rd_ent;
    logic [SP_SA_W-1:0]  sp_rd_sa;
    logic                sp_rd_valid;
    logic [ADDR_W-1:0]   sp_rd_pa;

    isb_training_unit #(.TU_ENTRIES(TU_ENTRIES)) u_tu (
        .clk(clk), .arst_n_i(arst_n_i), .acc_i(acc_i), .hit_o(tu_hit), .last_o(tu_last)
    );

    // lookup a at the last address of this pc, b at the current one
    isb_ps_amc u_ps (
        .clk(clk), .arst_n_i(arst_n_i),
        .addr_a_i(tu_last), .addr_b_i(acc_i.addr),
        .hit_a_o(hit_a), .hit_b_o(hit_b), .ent_a_o(ent_a), .ent_b_o(ent_b),
        .wr_a_i(ps_wr_a), .wr_b_i(ps_wr_b), .rd_idx_i(ps_rd_idx), .rd_ent_o(ps_rd_ent)
    );

    isb_sp_amc u_sp (
        .clk(clk), .arst_n_i(arst_n_i), .wr0_i(sp_wr0), .wr1_i(sp_wr1),
        .rd_sa_i(sp_rd_sa), .rd_valid_o(sp_rd_valid), .rd_pa_o(sp_rd_pa)
    );

    isb_trainer #(.SA_CHUNK(SA_CHUNK)) u_trainer (
        .clk(clk), .arst_n_i(arst_n_i), .acc_i(acc_i),
        .tu_hit_i(tu_hit), .tu_last_i(tu_last),
        .hit_a_i(hit_a), .hit_b_i(hit_b), .ent_a_i(ent_a), .ent_b_i(ent_b),
        .ps_wr_a_o(ps_wr_a), .ps_wr_b_o(ps_wr_b),
        .sp_wr0_o(sp_wr0), .sp_wr1_o(sp_wr1), .next_sa_o(next_sa)
    );

    isb_apb_regs u_apb (
        .clk(clk), .arst_n_i(arst_n_i),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i),
        .ps_rd_idx_o(ps_rd_idx), .ps_rd_i(ps_rd_ent),
        .sp_rd_sa_o(sp_rd_sa), .sp_valid_i(sp_rd_valid), .sp_pa_i(sp_rd_pa),
        .next_sa_i(next_sa),
        .prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o)
    );

endmodule

`default_nettype wire

//--- isb_trainer.sv
`default_nettype none

module isb_trainer #(
    parameter int SA_CHUNK = 16
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  isb_pkg::access_t           acc_i,
    input  logic                       tu_hit_i,
    input  logic [isb_pkg::ADDR_W-1:0] tu_last_i,
    input  logic                       hit_a_i,
    input  logic                       hit_b_i,
    input  isb_pkg::ps_entry_t         ent_a_i,
    input  isb_pkg::ps_entry_t         ent_b_i,
    output isb_pkg::ps_wr_t            ps_wr_a_o,
    output isb_pkg::ps_wr_t            ps_wr_b_o,
    output isb_pkg::sp_wr_t            sp_wr0_o,
    output isb_pkg::sp_wr_t            sp_wr1_o,
    output logic [isb_pkg::SA_W-1:0]   next_sa_o
);
    import isb_pkg::*;

    logic [SA_W-1:0] next_sa_q;
    logic            pair;
    train_case_e     tcase;
    logic            alloc_ok;
    logic            sa_alloc;
    logic [SA_W-1:0] next_inc;
    logic [SA_W-1:0] sa_a_inc;
    logic            a_inc_ok;

    function automatic ps_wr_t mk_ps(logic [ADDR_W-1:0] pa, logic [SA_W-1:0] sa,
                                     logic [CTR_W-1:0] ctr);
        ps_wr_t w;
        w.en = 1'b1;
        w.idx = pa[PS_IDX_W-1:0];
        w.ent = '{valid: 1'b1, tag: pa, sa: sa, ctr: ctr};
        return w;
    endfunction

    function automatic sp_wr_t mk_sp(logic [SA_W-1:0] sa, logic [ADDR_W-1:0] pa);
        sp_wr_t w;
        w.en = 1'b1;
        w.sa = sa[SP_SA_W-1:0];
        w.pa = pa;
        return w;
    endfunction

    // a = last miss of this pc, b = current address
    assign pair = tu_hit_i && (tu_last_i != acc_i.addr);
    assign tcase = train_case_e'({hit_a_i, hit_b_i});
    assign alloc_ok = next_sa_q < SA_W'(SA_SPACE);
    assign next_inc = next_sa_q + 1'b1;
    assign sa_a_inc = ent_a_i.sa + 1'b1;
    assign a_inc_ok = sa_a_inc < SA_W'(SA_SPACE);

    always_comb begin
        ps_wr_a_o = '0;
        ps_wr_b_o = '0;
        sp_wr0_o = '0;
        sp_wr1_o = '0;
        sa_alloc = 1'b0;
        if (pair) begin
            unique case (tcase)
                CASE_NEW_PAIR: begin
                    if (alloc_ok) begin
                        sa_alloc = 1'b1;
                        ps_wr_a_o = mk_ps(tu_last_i, next_sa_q, CTR_INIT);
                        ps_wr_b_o = mk_ps(acc_i.addr, next_inc, CTR_INIT);
                        sp_wr0_o = mk_sp(next_sa_q, tu_last_i);
                        sp_wr1_o = mk_sp(next_inc, acc_i.addr);
                    end
                end
                CASE_B_ONLY: begin
                    if (alloc_ok) begin
                        sa_alloc = 1'b1;
                        ps_wr_a_o = mk_ps(tu_last_i, next_sa_q, CTR_INIT);
                        sp_wr0_o = mk_sp(next_sa_q, tu_last_i);
                    end
                    // b follows a into the new chunk once confidence is spent
                    if (ent_b_i.ctr == CTR_W'(1) && alloc_ok) begin
                        ps_wr_b_o = mk_ps(acc_i.addr, next_inc, CTR_INIT);
                        sp_wr1_o = mk_sp(next_inc, acc_i.addr);
                    end else if (ent_b_i.ctr > CTR_W'(1)) begin
                        ps_wr_b_o = mk_ps(acc_i.addr, ent_b_i.sa, ent_b_i.ctr - 1'b1);
                    end
                end
                CASE_A_ONLY: begin
                    // extend the stream of a
                    if (a_inc_ok) begin
                        ps_wr_b_o = mk_ps(acc_i.addr, sa_a_inc, CTR_INIT);
                        sp_wr1_o = mk_sp(sa_a_inc, acc_i.addr);
                    end
                end
                CASE_BOTH: begin
                    if (ent_b_i.sa == sa_a_inc) begin
                        ps_wr_b_o = mk_ps(acc_i.addr, ent_b_i.sa,
                                          (ent_b_i.ctr == CTR_INIT) ? CTR_INIT
                                                                    : ent_b_i.ctr + 1'b1);
                    end else if (ent_b_i.ctr > CTR_W'(1)) begin
                        ps_wr_b_o = mk_ps(acc_i.addr, ent_b_i.sa, ent_b_i.ctr - 1'b1);
                    end else if (a_inc_ok) begin
                        // remap b right behind a
                        ps_wr_b_o = mk_ps(acc_i.addr, sa_a_inc, CTR_INIT);
                        sp_wr1_o = mk_sp(sa_a_inc, acc_i.addr);
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            next_sa_q <= '0;
        end else if (sa_alloc) begin
            next_sa_q <= next_sa_q + SA_W'(SA_CHUNK);
        end
    end

    assign next_sa_o = next_sa_q;

endmodule

`default_nettype wire

//--- isb_training_unit.sv
`default_nettype none

module isb_training_unit #(
    parameter int TU_ENTRIES = 4
) (
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  isb_pkg::access_t           acc_i,
    output logic                       hit_o,
    output logic [isb_pkg::ADDR_W-1:0] last_o
);
    import isb_pkg::*;

    localparam int IDX_W = (TU_ENTRIES > 1) ? $clog2(TU_ENTRIES) : 1;

    tu_entry_t        tab [TU_ENTRIES];
    // age 0 is most recently used, TU_ENTRIES-1 is the victim
    logic [IDX_W-1:0] age [TU_ENTRIES];
    logic             pc_match;
    logic [IDX_W-1:0] hit_idx;
    logic [IDX_W-1:0] lru_idx;
    logic [IDX_W-1:0] use_idx;

    // fully associative pc lookup and victim search
    always_comb begin
        pc_match = 1'b0;
        hit_idx = '0;
        lru_idx = '0;
        for (int i = 0; i < TU_ENTRIES; i++) begin
            if (!pc_match && tab[i].valid && tab[i].pc == acc_i.pc) begin
                pc_match = 1'b1;
                hit_idx = IDX_W'(i);
            end
            if (age[i] == IDX_W'(TU_ENTRIES - 1)) begin
                lru_idx = IDX_W'(i);
            end
        end
    end

    assign use_idx = pc_match ? hit_idx : lru_idx;
    assign hit_o = acc_i.valid && pc_match;
    assign last_o = tab[hit_idx].last;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < TU_ENTRIES; i++) begin
                tab[i] <= '0;
                // entry 0 starts as the oldest
                age[i] <= IDX_W'(TU_ENTRIES - 1 - i);
            end
        end else if (acc_i.valid) begin
            tab[use_idx] <= '{valid: 1'b1, pc: acc_i.pc, last: acc_i.addr};
            // entries younger than the used one age by one
            for (int i = 0; i < TU_ENTRIES; i++) begin
                if (IDX_W'(i) == use_idx) begin
                    age[i] <= '0;
                end else if (age[i] < age[use_idx]) begin
                    age[i] <= age[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_isb.sv
`default_nettype none

module tb_isb;
    timeunit 1ns;
    timeprecision 1ps;
    import isb_pkg::*;

    localparam int TU_ENTRIES = 4;
    localparam int SA_CHUNK = 16;
    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 10;
    localparam int N_RAND = 400;
    localparam int N_REGS = 65;
    // one table dump per random access plus the directed ones
    localparam int N_DUMPS = N_RAND + 6;
    localparam int ACC_CYCLES = N_RAND + 40;
    localparam int READ_CYCLES = 2 * (N_DUMPS * N_REGS + 8);
    localparam int RUN_CYCLES = ACC_CYCLES + READ_CYCLES + 2 * RST_CYCLES;

    localparam logic [ADDR_W-1:0] PC_1 = 16'h0100;
    localparam logic [ADDR_W-1:0] PC_2 = 16'h0200;
    localparam logic [ADDR_W-1:0] PC_3 = 16'h0300;
    localparam logic [ADDR_W-1:0] PC_4 = 16'h0400;
    localparam logic [ADDR_W-1:0] ADDR_X = 16'h1001;
    localparam logic [ADDR_W-1:0] ADDR_Y = 16'h2002;
    localparam logic [ADDR_W-1:0] ADDR_Z = 16'h3003;

    logic        clk;
    logic        arst_n;
    access_t     acc;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] lfsr_state;

    isb_top #(.TU_ENTRIES(TU_ENTRIES), .SA_CHUNK(SA_CHUNK)) UUT (
        .clk(clk), .arst_n_i(arst_n), .acc_i(acc),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata),
        .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
    );

    tb_isb_checker #(.TU_ENTRIES(TU_ENTRIES), .SA_CHUNK(SA_CHUNK)) u_chk (
        .clk(clk), .arst_n_i(arst_n), .acc_i(acc),
        .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
        .prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD * 2);
        $display("watchdog expired after %0d cycles, run did not finish", RUN_CYCLES * 2);
        $display("Simulation FAILED");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic logic [ADDR_W-1:0] pool_pc(input int k);
        return ADDR_W'(16'h0100 * (k + 1));
    endfunction

    // three addresses per ps index so lookups alias
    function automatic logic [ADDR_W-1:0] pool_addr(input int k);
        return ADDR_W'(16'h1000 * ((k % 3) + 1) + 5 * (k / 3));
    endfunction

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic send_access(input logic [ADDR_W-1:0] pc, input logic [ADDR_W-1:0] addr);
        acc.valid = 1'b1;
        acc.pc = pc;
        acc.addr = addr;
        @(posedge clk);
        #1;
        acc.valid = 1'b0;
    endtask

    task automatic apb_xfer(input logic [7:0] addr, input logic write, input logic [31:0] wdata);
        int waited;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waited = 0;
        @(negedge clk);
        while (pready !== 1'b1 && waited < 4) begin
            waited++;
            @(negedge clk);
        end
        if (pready !== 1'b1) begin
            u_chk.note_failure($sformatf("pready never rose for APB address 0x%02h", addr));
        end
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic read_all();
        for (int a = 0; a < N_REGS; a++) begin
            apb_xfer(8'(a), 1'b0, 32'h0);
        end
    endtask

    initial begin : main
        int pi;
        int ai;
        int total_errors;
        acc = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        arst_n = 1'b0;
        lfsr_state = 32'h31eb_3524;
        apply_reset();

        u_chk.start_test("reset_state");
        read_all();
        u_chk.finish_test();

        u_chk.start_test("new_pair");
        send_access(PC_1, ADDR_X);
        send_access(PC_1, ADDR_Y);
        read_all();
        u_chk.finish_test();

        u_chk.start_test("extend_confidence");
        send_access(PC_1, ADDR_Z);
        send_access(PC_1, ADDR_X);
        send_access(PC_1, ADDR_Y);
        read_all();
        u_chk.finish_test();

        u_chk.start_test("divergence_remap");
        send_access(PC_2, ADDR_Z);
        send_access(PC_2, ADDR_Y);
        // x then y again lifts ctr(y) back up
        send_access(PC_1, ADDR_X);
        send_access(PC_1, ADDR_Y);
        repeat (3) begin
            send_access(PC_2, ADDR_Z);
            send_access(PC_2, ADDR_Y);
        end
        read_all();
        send_access(PC_3, 16'h4004);
        send_access(PC_3, 16'h5005);
        send_access(PC_3, 16'h6006);
        // allocator is exhausted here
        send_access(PC_4, 16'h7007);
        send_access(PC_4, 16'h8008);
        read_all();
        u_chk.finish_test();

        u_chk.start_test("apb_errors");
        apb_xfer(8'h00, 1'b1, 32'hdead_beef);
        apb_xfer(8'h40, 1'b1, 32'hffff_ffff);
        apb_xfer(8'h41, 1'b0, 32'h0);
        apb_xfer(8'h80, 1'b0, 32'h0);
        apb_xfer(8'hff, 1'b0, 32'h0);
        u_chk.finish_test();

        u_chk.start_test("random_traffic");
        apply_reset();
        for (int n = 0; n < N_RAND; n++) begin
            take_bits(3, pi);
            take_bits(4, ai);
            send_access(pool_pc(pi % 6), pool_addr(ai % 12));
            read_all();
        end
        u_chk.finish_test();

        total_errors = u_chk.err_count + UUT.u_isb_assertions.fail_count;
        $display("summary: %0d tests, %0d reads checked, %0d errors, %0d assertion failures",
                 u_chk.test_count, u_chk.check_count, u_chk.err_count,
                 UUT.u_isb_assertions.fail_count);
        if (total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_isb_checker.sv
`default_nettype none

module tb_isb_checker #(
    parameter int TU_ENTRIES = 4,
    parameter int SA_CHUNK = 16
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  isb_pkg::access_t acc_i,
    input  logic             psel_i,
    input  logic             penable_i,
    input  logic             pwrite_i,
    input  logic [7:0]       paddr_i,
    input  logic [31:0]      prdata_i,
    input  logic             pready_i,
    input  logic             pslverr_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import isb_pkg::*;

    // model tables, tu queue keeps the most recent pc at the back
    tu_entry_t         tu_q [$];
    ps_entry_t         ps_m [PS_ENTRIES];
    logic              sp_v [SA_SPACE];
    logic [ADDR_W-1:0] sp_pa [SA_SPACE];
    int                next_sa_m;

    string cur_test = "none";
    int    test_count = 0;
    int    check_count = 0;
    int    err_count = 0;
    int    test_checks = 0;
    int    test_errors = 0;

    function automatic void model_reset();
        tu_q.delete();
        for (int i = 0; i < PS_ENTRIES; i++) begin
            ps_m[i] = '0;
        end
        for (int i = 0; i < SA_SPACE; i++) begin
            sp_v[i] = 1'b0;
            sp_pa[i] = '0;
        end
        next_sa_m = 0;
    endfunction

    function automatic void set_map(input logic [ADDR_W-1:0] pa, input int sa, input int ctr,
                                    input logic sp_too);
        ps_m[pa[PS_IDX_W-1:0]].valid = 1'b1;
        ps_m[pa[PS_IDX_W-1:0]].tag = pa;
        ps_m[pa[PS_IDX_W-1:0]].sa = SA_W'(sa);
        ps_m[pa[PS_IDX_W-1:0]].ctr = CTR_W'(ctr);
        if (sp_too) begin
            sp_v[sa] = 1'b1;
            sp_pa[sa] = pa;
        end
    endfunction

    // reference for one access, applied in the order the rules give
    function automatic void model_step(input access_t acc);
        int                hit_pos;
        tu_entry_t         ent;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        ps_entry_t         ea;
        ps_entry_t         eb;
        logic              ha;
        logic              hb;
        int                ns;
        int                s;
        if (!acc.valid) begin
            return;
        end
        hit_pos = -1;
        foreach (tu_q[i]) begin
            if (tu_q[i].pc == acc.pc) begin
                hit_pos = i;
            end
        end
        a = '0;
        b = acc.addr;
        if (hit_pos >= 0) begin
            a = tu_q[hit_pos].last;
            tu_q.delete(hit_pos);
        end else if (tu_q.size() == TU_ENTRIES) begin
            tu_q.delete(0);
        end
        ent.valid = 1'b1;
        ent.pc = acc.pc;
        ent.last = acc.addr;
        tu_q.push_back(ent);
        if (hit_pos < 0 || a == b) begin
            return;
        end
        ea = ps_m[a[PS_IDX_W-1:0]];
        eb = ps_m[b[PS_IDX_W-1:0]];
        ha = ea.valid && ea.tag == a;
        hb = eb.valid && eb.tag == b;
        ns = next_sa_m;
        s = int'(ea.sa) + 1;
        if (!ha && !hb) begin
            if (ns < SA_SPACE) begin
                set_map(a, ns, 3, 1'b1);
                set_map(b, ns + 1, 3, 1'b1);
                next_sa_m = ns + SA_CHUNK;
            end
        end else if (!ha) begin
            if (ns < SA_SPACE) begin
                set_map(a, ns, 3, 1'b1);
                next_sa_m = ns + SA_CHUNK;
            end
            if (eb.ctr == 1 && ns < SA_SPACE) begin
                set_map(b, ns + 1, 3, 1'b1);
            end else if (eb.ctr > 1) begin
                set_map(b, eb.sa, eb.ctr - 1, 1'b0);
            end
        end else if (!hb) begin
            if (s < SA_SPACE) begin
                set_map(b, s, 3, 1'b1);
            end
        end else begin
            if (int'(eb.sa) == s) begin
                set_map(b, eb.sa, (eb.ctr == 3) ? 3 : eb.ctr + 1, 1'b0);
            end else if (eb.ctr > 1) begin
                set_map(b, eb.sa, eb.ctr - 1, 1'b0);
            end else if (s < SA_SPACE) begin
                set_map(b, s, 3, 1'b1);
            end
        end
    endfunction

    // {pslverr, prdata} for one read of the register map
    function automatic logic [32:0] expected_read(input logic [7:0] addr, input logic write);
        logic [31:0] d;
        ps_entry_t   e;
        int          sa;
        d = '0;
        if (write || addr > 8'h40) begin
            return {1'b1, 32'h0};
        end
        if (addr < 8'h20) begin
            e = ps_m[addr[PS_IDX_W-1:0]];
            d[31] = e.valid;
            d[29:28] = e.ctr;
            d[21:16] = e.sa;
            d[15:0] = e.tag;
        end else if (addr < 8'h40) begin
            sa = int'(addr) - 32'h20;
            d[31] = sp_v[sa];
            d[15:0] = sp_pa[sa];
        end else begin
            d[5:0] = 6'(next_sa_m);
        end
        return {1'b0, d};
    endfunction

    // address field of an empty sp slot is undefined
    function automatic logic [31:0] read_mask(input logic [7:0] addr, input logic write);
        if (!write && addr >= 8'h20 && addr < 8'h40 && !sp_v[int'(addr) - 32'h20]) begin
            return 32'hffff_0000;
        end
        return 32'hffff_ffff;
    endfunction

    task automatic start_test(input string name);
        cur_test = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        test_count++;
        $display("test %-18s %0d reads, %0d errors", cur_test, test_checks, test_errors);
    endtask

    task automatic note_failure(input string msg);
        err_count++;
        test_errors++;
        $display("Error in test %s: %s", cur_test, msg);
    endtask

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            model_reset();
        end else begin
            model_step(acc_i);
        end
    end

    // access phase is stable at the falling edge
    always @(negedge clk) begin : compare
        logic [32:0] exp_rd;
        logic [31:0] mask;
        if (arst_n_i && psel_i && penable_i && pready_i) begin
            exp_rd = expected_read(paddr_i, pwrite_i);
            mask = read_mask(paddr_i, pwrite_i);
            check_count++;
            test_checks++;
            if ({pslverr_i, prdata_i & mask} !== {exp_rd[32], exp_rd[31:0] & mask}) begin
                err_count++;
                test_errors++;
                $display("Mismatch in test %s at addr 0x%02h: expected %08h err %0b, actual %08h err %0b",
                         cur_test, paddr_i, exp_rd[31:0], exp_rd[32], prdata_i, pslverr_i);
            end
        end
    end

endmodule

`default_nettype wire
